/* alu_regs.f */
+incdir+.
alu_regs_pkg.sv
instr_decoder.sv
alu_core.sv
reg_bank.sv
alu_regs_top.sv
tb_alu_regs.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run, exit status follows the simulation
verilator --binary --timing -Wno-fatal -f alu_regs.f --top-module tb_alu_regs \
    -o tb_alu_regs \
    && ./obj_dir/tb_alu_regs \
    || { echo "simulation run failed"; exit 1; }

/* tb_alu_model.svh */
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Maps a one-hot select to a register index, -1 if not one-hot among the four
function automatic int onehot_index(input logic [7:0] sel);
    case (sel)
        8'h01:   onehot_index = 0;
        8'h02:   onehot_index = 1;
        8'h04:   onehot_index = 2;
        8'h08:   onehot_index = 3;
        default: onehot_index = -1;
    endcase
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////
task automatic model_exec(input instr_t ins, inout reg_file_t r, inout flags_t f,
                          output bit accepted);
    int          d;
    int          s;
    bit          known;
    bit          reg_form;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  res;
    logic [15:0] p;
    d        = onehot_index(ins.dst);
    s        = onehot_index(ins.operand);
    known    = 1'b1;
    reg_form = 1'b0;
    case (ins.opcode)
        save_reg, sum_reg, sub_reg, mul_reg: reg_form = 1'b1;
        save_op, sum_op, sub_op, mul_op, shift_r, shift_l: reg_form = 1'b0;
        default: known = 1'b0;
    endcase
    accepted = known && (d >= 0) && (!reg_form || s >= 0);
    if (accepted) begin
        a   = r[d];
        b   = reg_form ? r[s] : ins.operand;
        res = 8'h00;
        p   = {8'h00, a} * {8'h00, b};
        case (ins.opcode)
            save_op, save_reg: res = b;
            sum_op, sum_reg:   res = a + b;
            sub_op, sub_reg:   res = a - b;
            shift_r:           res = (b >= 8'd8) ? 8'h00 : (a >> b);
            shift_l:           res = (b >= 8'd8) ? 8'h00 : (a << b);
            default:           res = 8'h00;
        endcase
        if (ins.opcode == mul_op || ins.opcode == mul_reg) begin
            r[0] = p[7:0];  // Low byte to ra
            r[3] = p[15:8];
            f.sf = p[15];
            f.zf = (p == 16'h0000);
        end else begin
            r[d] = res;
            f.sf = res[7];
            f.zf = (res == 8'h00);
        end
    end
endtask

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////
task automatic compare_regs(input reg_file_t got, input reg_file_t want);
    if (got !== want) begin
        stop_with_error($sformatf("** Error: regs got 0x%h expected 0x%h", got, want));
    end
endtask

task automatic compare_flags(input flags_t got, input flags_t want);
    if (got !== want) begin
        stop_with_error($sformatf("** Error: flags got 0x%h expected 0x%h", got, want));
    end
endtask

`endif

/* tb_alu_regs.sv */
`timescale 1ns/1ns

module tb_alu_regs import alu_regs_pkg::*; ();

    localparam int NUM_INSTR = 3000;

    typedef struct packed {
        reg_file_t   regs;
        flags_t      flags;
        logic [31:0] edge_no;  // Edge where the instruction was sampled
    } exp_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    instr_t    instr;
    reg_file_t regs;
    flags_t    flags;
    logic      done;

    logic [31:0] cycle_cnt = '0;
    logic [31:0] lcg_state;
    reg_file_t   model_regs;
    flags_t      model_flags;
    reg_file_t   shown_regs;   // State the DUT should show right now
    flags_t      shown_flags;
    exp_t        exp_q[$];

    logic [3:0] legal_ops [0:9] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5,
                                    4'd6, 4'd7, 4'd8, 4'd11, 4'd12};
    logic [3:0] illegal_ops [0:5] = '{4'd0, 4'd9, 4'd10, 4'd13, 4'd14, 4'd15};

    alu_regs_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .regs     (regs),
        .flags    (flags),
        .done     (done)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    `include "tb_alu_model.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        #((NUM_INSTR + 4 + 64) * 8);
        stop_with_error("Watchdog timeout, the run did not complete in time");
    end

    ////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////
    task automatic make_instr(output logic valid, output instr_t ins);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  op;
        logic [7:0]  dst;
        logic [7:0]  opnd;
        lcg_state = lcg_next(lcg_state);
        r1 = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r2 = lcg_state;
        valid = (r1[31:30] != 2'b00);
        if (r1[29:26] == 4'h0) op = illegal_ops[r1[25:23] % 6];
        else op = legal_ops[r1[25:22] % 10];
        if (r1[21:19] == 3'd0) dst = r2[31:24];  // Mostly junk selects
        else dst = 8'h01 << r1[18:17];
        if ((op inside {4'd2, 4'd4, 4'd6, 4'd8}) && r1[16:14] != 3'd0) begin
            opnd = 8'h01 << r2[23:22];
        end else if (r1[13:12] == 2'b00) begin
            opnd = 8'h00;
        end else if ((op inside {4'd11, 4'd12}) && r1[11]) begin
            opnd = {4'h0, r2[11:8]};  // Short shift counts
        end else begin
            opnd = r2[23:16];
        end
        ins = instr_t'({op, dst, opnd});
    endtask

    task automatic check_outputs();
        exp_t e;
        if (done) begin
            if (exp_q.size() == 0) begin
                stop_with_error("Done pulse seen with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                if (cycle_cnt != e.edge_no + 1) begin
                    stop_with_error($sformatf("Done at edge %0d for instruction sampled at %0d",
                                              cycle_cnt, e.edge_no));
                end
                shown_regs  = e.regs;
                shown_flags = e.flags;
            end
        end else if (exp_q.size() != 0 && cycle_cnt > exp_q[0].edge_no + 1) begin
            stop_with_error("Done pulse missing for an accepted instruction");
        end
        compare_regs(regs, shown_regs);
        compare_flags(flags, shown_flags);
    endtask

    initial begin
        logic   v;
        instr_t ins;
        bit     acc;
        exp_t   e;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        instr       = '0;
        lcg_state   = 32'd29570;
        model_regs  = '0;
        model_flags = '0;
        shown_regs  = '0;
        shown_flags = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            @(negedge clk);
            check_outputs();
            make_instr(v, ins);
            in_valid = v;
            instr    = ins;
            if (v) begin
                model_exec(ins, model_regs, model_flags, acc);
                if (acc) begin
                    e.regs    = model_regs;
                    e.flags   = model_flags;
                    e.edge_no = cycle_cnt + 1;
                    exp_q.push_back(e);
                end
            end
        end
        repeat (4) begin  // Drain the pipeline
            @(negedge clk);
            check_outputs();
            in_valid = 1'b0;
        end
        if (exp_q.size() != 0) begin
            stop_with_error("Expected results were left unchecked at the end of the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* alu_regs_top.sv */
`timescale 1ns/1ns

module alu_regs_top import alu_regs_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  instr_t    instr,
    output reg_file_t regs,
    output flags_t    flags,
    output logic      done
);

    ctrl_t ctrl;
    logic  ctrl_valid;
    wb_t   wb;

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////
    instr_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .instr      (instr),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid)
    );

    ////////////////////////////////////////
    // Execute and write-back
    ////////////////////////////////////////
    alu_core u_alu (
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .regs       (regs),
        .wb         (wb)
    );

    reg_bank u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb),
        .regs  (regs),
        .flags (flags),
        .done  (done)
    );

endmodule

/* reg_bank.sv */
`timescale 1ns/1ns

module reg_bank import alu_regs_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  wb_t       wb,
    output reg_file_t regs,
    output flags_t    flags,
    output logic      done
);

    ////////////////////////////////////////
    // Register file write-back
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wb.we) begin
            if (wb.pair) begin
                regs[IDX_RA] <= wb.lo;  // Low byte
                regs[IDX_RD] <= wb.hi;  // High byte
            end else begin
                regs[wb.dst] <= wb.lo;
            end
        end
    end

    // Flags follow every executed instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (wb.we) begin
            flags <= wb.flags;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= wb.we;  // One pulse per write-back
        end
    end

endmodule

/* alu_core.sv */
`timescale 1ns/1ns

module alu_core import alu_regs_pkg::*; (
    input  ctrl_t     ctrl,
    input  logic      ctrl_valid,
    input  reg_file_t regs,
    output wb_t       wb
);

    logic [DATA_W-1:0]   op_a;
    logic [DATA_W-1:0]   op_b;
    logic [2*DATA_W-1:0] prod;
    logic [DATA_W-1:0]   res;
    logic                is_mul;
    flags_t              flags;

    ////////////////////////////////////////
    // Operands
    ////////////////////////////////////////
    assign op_a = regs[ctrl.dst];
    assign op_b = ctrl.use_reg ? regs[ctrl.src] : ctrl.operand;

    assign prod   = op_a * op_b;  // Full 16-bit product
    assign is_mul = (ctrl.func == mul);

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.func)
            move: res = op_b;
            add:  res = op_a + op_b;  // Wraps mod 256
            sub:  res = op_a - op_b;
            mul:  res = prod[DATA_W-1:0];
            shr: begin
                if (op_b >= DATA_W) begin
                    res = '0;
                end else begin
                    res = op_a >> op_b[2:0];
                end
            end
            shl: begin
                if (op_b >= DATA_W) begin
                    res = '0;
                end else begin
                    res = op_a << op_b[2:0];
                end
            end
            default: res = op_a;
        endcase
    end

    // Multiply flags look at the whole product
    always_comb begin
        if (is_mul) begin
            flags.sf = prod[2*DATA_W-1];
            flags.zf = (prod == '0);
        end else begin
            flags.sf = res[DATA_W-1];
            flags.zf = (res == '0);
        end
    end

    assign wb.we    = ctrl_valid;
    assign wb.pair  = is_mul;
    assign wb.dst   = ctrl.dst;
    assign wb.lo    = res;
    assign wb.hi    = prod[2*DATA_W-1:DATA_W];  // Only used on pair writes
    assign wb.flags = flags;

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder import alu_regs_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  instr_t instr,
    output ctrl_t  ctrl,
    output logic   ctrl_valid
);

    // Returns {valid, index} for a one-hot select
    function automatic logic [2:0] sel_to_idx(input logic [DATA_W-1:0] sel);
        case (sel)
            ra:      sel_to_idx = {1'b1, IDX_RA};
            rb:      sel_to_idx = {1'b1, IDX_RB};
            rc:      sel_to_idx = {1'b1, IDX_RC};
            rd:      sel_to_idx = {1'b1, IDX_RD};
            default: sel_to_idx = {1'b0, IDX_RA};
        endcase
    endfunction

    alu_func_e func;
    logic      use_reg;
    logic      op_ok;
    logic [2:0] dst_dec;
    logic [2:0] src_dec;
    logic      legal;
    ctrl_t     ctrl_d;

    ////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////
    always_comb begin
        func    = move;
        use_reg = 1'b0;
        op_ok   = 1'b1;
        case (instr.opcode)
            save_op:  func = move;
            save_reg: begin func = move; use_reg = 1'b1; end
            sum_op:   func = add;
            sum_reg:  begin func = add;  use_reg = 1'b1; end
            sub_op:   func = sub;
            sub_reg:  begin func = sub;  use_reg = 1'b1; end
            mul_op:   func = mul;
            mul_reg:  begin func = mul;  use_reg = 1'b1; end
            shift_r:  func = shr;        // Count is always immediate
            shift_l:  func = shl;
            default:  op_ok = 1'b0;
        endcase
    end

    assign dst_dec = sel_to_idx(instr.dst);
    assign src_dec = sel_to_idx(instr.operand);

    // Bad source only matters for register forms
    assign legal = in_valid && op_ok && dst_dec[2] && (!use_reg || src_dec[2]);

    assign ctrl_d = '{func:    func,
                      dst:     dst_dec[1:0],
                      src:     src_dec[1:0],
                      use_reg: use_reg,
                      operand: instr.operand};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= legal;
        end
    end

    always_ff @(posedge clk) begin
        if (legal) begin
            ctrl <= ctrl_d;
        end
    end

endmodule

/* alu_regs_pkg.sv */
package alu_regs_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int DATA_W   = 8;
    localparam int NUM_REGS = 4;

    // Instruction opcodes, gaps are illegal
    typedef enum logic [3:0] {
        save_op  = 4'd1,
        save_reg = 4'd2,
        sum_op   = 4'd3,
        sum_reg  = 4'd4,
        sub_op   = 4'd5,
        sub_reg  = 4'd6,
        mul_op   = 4'd7,
        mul_reg  = 4'd8,
        shift_r  = 4'd11,
        shift_l  = 4'd12
    } opcode_e;

    // One-hot register selects as seen in the instruction
    typedef enum logic [7:0] {
        ra = 8'b0000_0001,
        rb = 8'b0000_0010,
        rc = 8'b0000_0100,
        rd = 8'b0000_1000
    } reg_flag_e;

    typedef logic [1:0] reg_idx_t;

    localparam reg_idx_t IDX_RA = 2'd0;
    localparam reg_idx_t IDX_RB = 2'd1;
    localparam reg_idx_t IDX_RC = 2'd2;
    localparam reg_idx_t IDX_RD = 2'd3;

    typedef enum logic [2:0] {
        move,
        add,
        sub,
        mul,
        shr,
        shl
    } alu_func_e;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////
    typedef struct packed {
        opcode_e           opcode;
        logic [DATA_W-1:0] dst;
        logic [DATA_W-1:0] operand;
    } instr_t;

    typedef struct packed {
        alu_func_e         func;
        reg_idx_t          dst;
        reg_idx_t          src;
        logic              use_reg;  // Operand B from src register
        logic [DATA_W-1:0] operand;
    } ctrl_t;

    typedef struct packed {
        logic sf;
        logic zf;
    } flags_t;

    typedef logic [NUM_REGS-1:0][DATA_W-1:0] reg_file_t;

    typedef struct packed {
        logic              we;
        logic              pair;     // Multiply, lo to ra and hi to rd
        reg_idx_t          dst;
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        flags_t            flags;
    } wb_t;

endpackage
